// File: Bender.yml
package:
  name: kinpira

sources:
  - design/kinpira_pkg.sv
  - design/regmap_pkg.sv
  - design/kinpira_ifs.sv
  - design/weight_mem.sv
  - design/image_buffer.sv
  - design/param_regs.sv
  - design/fc_ctrl.sv
  - design/fc_counter.sv
  - design/fc_mac.sv
  - design/kinpira_top.sv
  - target: test
    files:
      - testbench/tb_kinpira.sv

// File: design/fc_counter.sv
`default_nettype none

module fc_counter
  import kinpira_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      xrst,
  layer_cfg_if.engine    cfg,
  fc_step_if.counter     step,
  img_port_if.counter    img,
  output net_addr_t      net_raddr,
  input  wire img_addr_t write_addr
);

  layer_len_t in_idx;
  layer_len_t out_idx;
  net_addr_t  w_idx;

  assign step.in_last   = (in_idx == cfg.total_in - 1'b1);
  assign step.out_last  = (out_idx == cfg.total_out - 1'b1);
  assign step.out_index = out_idx;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_idx  <= '0;
      out_idx <= '0;
      w_idx   <= '0;
    end else begin
      if (step.run) begin
        in_idx <= step.in_last ? '0 : in_idx + 1'b1;
        w_idx  <= w_idx + 1'b1;
      end
      // Output index moves once the result is written
      if (step.write) begin
        out_idx <= step.out_last ? '0 : out_idx + 1'b1;
        if (step.out_last) begin
          w_idx <= '0;
        end
      end
    end
  end

  // Weights of consecutive outputs lie back to back
  assign net_raddr = cfg.net_offset + w_idx;
  assign img.addr  = step.write ? write_addr : cfg.in_offset + in_idx;

  // Align with the one cycle memory latency
  always_ff @(posedge clk) begin
    if (!xrst) begin
      step.data_valid <= 1'b0;
      step.data_last  <= 1'b0;
    end else begin
      step.data_valid <= step.run;
      step.data_last  <= step.run && step.in_last;
    end
  end

endmodule

`default_nettype wire

// File: design/fc_ctrl.sv
`default_nettype none

module fc_ctrl
  import kinpira_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   xrst,
  input  wire logic   req,
  layer_cfg_if.engine cfg,
  fc_step_if.ctrl     step,
  output logic        ack
);

  typedef enum logic [2:0] {S_IDLE, S_ACC, S_DRAIN, S_WRITE, S_DONE} state_t;

  state_t state;
  state_t next_state;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    step.clear = 1'b0;
    step.write = 1'b0;
    case (state)
      S_IDLE: begin
        if (req) begin
          // Empty layer finishes at once
          if (cfg.total_in == '0 || cfg.total_out == '0) begin
            next_state = S_DONE;
          end else begin
            step.clear = 1'b1;
            next_state = S_ACC;
          end
        end
      end
      S_ACC: begin
        if (step.in_last) begin
          next_state = S_DRAIN;
        end
      end
      S_DRAIN: next_state = S_WRITE;
      S_WRITE: begin
        if (step.result_ready) begin
          step.write = 1'b1;
          if (step.out_last) begin
            next_state = S_DONE;
          end else begin
            step.clear = 1'b1;
            next_state = S_ACC;
          end
        end
      end
      S_DONE: begin
        if (!req) begin
          next_state = S_IDLE;
        end
      end
      default: next_state = S_IDLE;
    endcase
  end

  assign step.run = (state == S_ACC);
  assign ack      = (state == S_DONE);

endmodule

`default_nettype wire

// File: design/fc_mac.sv
`default_nettype none

module fc_mac
  import kinpira_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      xrst,
  fc_step_if.mac         step,
  img_port_if.mac        img,
  input  wire data_t     net_rdata,
  input  wire img_addr_t out_offset,
  output img_addr_t      write_addr
);

  acc_t  acc;
  acc_t  prod;
  acc_t  sum;
  acc_t  shifted;
  data_t result;

  assign prod    = img.rdata * net_rdata;
  assign sum     = acc + prod;
  assign shifted = sum >>> FRAC_BITS;

  always_ff @(posedge clk) begin
    if (step.clear || (step.data_valid && step.data_last)) begin
      acc <= '0;
    end else if (step.data_valid) begin
      acc <= sum;
    end
  end

  // Close the sum and hold the saturated result
  always_ff @(posedge clk) begin
    if (step.data_valid && step.data_last) begin
      if (shifted > DATA_MAX) begin
        result <= DATA_MAX[DWIDTH-1:0];
      end else if (shifted < DATA_MIN) begin
        result <= DATA_MIN[DWIDTH-1:0];
      end else begin
        result <= shifted[DWIDTH-1:0];
      end
      write_addr <= out_offset + step.out_index;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      step.result_ready <= 1'b0;
    end else if (step.data_valid && step.data_last) begin
      step.result_ready <= 1'b1;
    end else if (step.write) begin
      step.result_ready <= 1'b0;
    end
  end

  assign img.we    = step.write;
  assign img.wdata = result;

endmodule

`default_nettype wire

// File: design/image_buffer.sv
`default_nettype none

module image_buffer
  import kinpira_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      host_sel,
  input  wire logic      host_we,
  input  wire img_addr_t host_addr,
  input  wire data_t     host_wdata,
  output data_t          host_rdata,
  img_port_if.buffer     eng
);

  data_t     mem [2**IMGSIZE];
  data_t     rdata;
  logic      we;
  img_addr_t addr;
  data_t     wdata;

  // Port owned by host or engine
  always_comb begin
    if (host_sel) begin
      we    = host_we;
      addr  = host_addr;
      wdata = host_wdata;
    end else begin
      we    = eng.we;
      addr  = eng.addr;
      wdata = eng.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  assign host_rdata = rdata;
  assign eng.rdata  = rdata;

endmodule

`default_nettype wire

// File: design/kinpira_ifs.sv
`default_nettype none

// Layer settings from the host registers
interface layer_cfg_if import kinpira_pkg::*; ();
  img_addr_t  in_offset;
  img_addr_t  out_offset;
  net_addr_t  net_offset;
  layer_len_t total_in;
  layer_len_t total_out;

  modport regs   (output in_offset, out_offset, net_offset, total_in, total_out);
  modport engine (input  in_offset, out_offset, net_offset, total_in, total_out);
endinterface

// Engine side of the image buffer
interface img_port_if import kinpira_pkg::*; ();
  logic      we;
  img_addr_t addr;
  data_t     wdata;
  data_t     rdata;

  modport buffer  (input we, addr, wdata, output rdata);
  modport counter (output addr);
  modport mac     (output we, wdata, input rdata);
endinterface

interface fc_step_if import kinpira_pkg::*; ();
  logic       clear;
  logic       run;
  logic       write;
  logic       in_last;
  logic       out_last;
  layer_len_t out_index;
  logic       data_valid;
  logic       data_last;
  logic       result_ready;

  modport ctrl    (output clear, run, write, input in_last, out_last, result_ready);
  modport counter (input run, write,
                   output in_last, out_last, out_index, data_valid, data_last);
  modport mac     (input clear, write, out_index, data_valid, data_last,
                   output result_ready);
endinterface

`default_nettype wire

// File: design/kinpira_pkg.sv
`default_nettype none

package kinpira_pkg;

  // Datapath widths
  localparam int DWIDTH    = 16;
  localparam int IMGSIZE   = 10;
  localparam int NETSIZE   = 10;
  localparam int LWIDTH    = 10;
  localparam int ACCWIDTH  = 40;

  // Fixed point
  localparam int FRAC_BITS = 8;

  typedef logic signed [DWIDTH-1:0]   data_t;
  typedef logic        [IMGSIZE-1:0]  img_addr_t;
  typedef logic        [NETSIZE-1:0]  net_addr_t;
  typedef logic        [LWIDTH-1:0]   layer_len_t;
  typedef logic signed [ACCWIDTH-1:0] acc_t;
  typedef logic        [1:0]          owner_t;

  // Saturation bounds of a data word
  localparam acc_t DATA_MAX = acc_t'(2 ** (DWIDTH - 1) - 1);
  localparam acc_t DATA_MIN = -acc_t'(2 ** (DWIDTH - 1));

  // Image buffer owners
  localparam owner_t OWNER_HOST = 2'd0;
  localparam owner_t OWNER_FC   = 2'd1;

endpackage

`default_nettype wire

// File: design/kinpira_top.sv
`default_nettype none

module kinpira_top
  import kinpira_pkg::*;
  import regmap_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      xrst,
  input  wire logic      reg_we,
  input  wire reg_addr_t reg_addr,
  input  wire reg_data_t reg_wdata,
  output reg_data_t      reg_rdata,
  input  wire logic      img_we,
  input  wire img_addr_t img_addr,
  input  wire data_t     img_wdata,
  output data_t          img_rdata,
  input  wire logic      net_we,
  input  wire net_addr_t net_addr,
  input  wire data_t     net_wdata
);

  layer_cfg_if cfg ();
  img_port_if  img_port ();
  fc_step_if   step ();

  logic      host_sel;
  logic      fc_req;
  logic      ack;
  net_addr_t net_raddr;
  data_t     net_rdata;
  img_addr_t write_addr;

  param_regs i_param_regs (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .cfg       (cfg.regs),
    .host_sel  (host_sel),
    .fc_req    (fc_req),
    .ack       (ack)
  );

  image_buffer i_image_buffer (
    .clk        (clk),
    .host_sel   (host_sel),
    .host_we    (img_we),
    .host_addr  (img_addr),
    .host_wdata (img_wdata),
    .host_rdata (img_rdata),
    .eng        (img_port.buffer)
  );

  weight_mem #(
    .DATA_BITS (DWIDTH),
    .ADDR_BITS (NETSIZE)
  ) i_weight_mem (
    .clk   (clk),
    .we    (net_we),
    .waddr (net_addr),
    .wdata (net_wdata),
    .raddr (net_raddr),
    .rdata (net_rdata)
  );

  fc_ctrl i_fc_ctrl (
    .clk  (clk),
    .xrst (xrst),
    .req  (fc_req),
    .cfg  (cfg.engine),
    .step (step.ctrl),
    .ack  (ack)
  );

  fc_counter i_fc_counter (
    .clk        (clk),
    .xrst       (xrst),
    .cfg        (cfg.engine),
    .step       (step.counter),
    .img        (img_port.counter),
    .net_raddr  (net_raddr),
    .write_addr (write_addr)
  );

  fc_mac i_fc_mac (
    .clk        (clk),
    .xrst       (xrst),
    .step       (step.mac),
    .img        (img_port.mac),
    .net_rdata  (net_rdata),
    .out_offset (cfg.out_offset),
    .write_addr (write_addr)
  );

endmodule

`default_nettype wire

// File: design/param_regs.sv
`default_nettype none

module param_regs
  import kinpira_pkg::*;
  import regmap_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      xrst,
  input  wire logic      reg_we,
  input  wire reg_addr_t reg_addr,
  input  wire reg_data_t reg_wdata,
  output reg_data_t      reg_rdata,
  layer_cfg_if.regs      cfg,
  output logic           host_sel,
  output logic           fc_req,
  input  wire logic      ack
);

  owner_t owner;
  owner_t owner_d;
  logic   req;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      owner          <= OWNER_HOST;
      owner_d        <= OWNER_HOST;
      req            <= 1'b0;
      cfg.in_offset  <= '0;
      cfg.out_offset <= '0;
      cfg.net_offset <= '0;
      cfg.total_out  <= '0;
      cfg.total_in   <= '0;
    end else begin
      owner_d <= owner;
      if (reg_we) begin
        case (reg_addr)
          REG_OWNER:      owner          <= reg_wdata[$bits(owner_t)-1:0];
          REG_REQ:        req            <= reg_wdata[0];
          REG_IN_OFFSET:  cfg.in_offset  <= reg_wdata[IMGSIZE-1:0];
          REG_OUT_OFFSET: cfg.out_offset <= reg_wdata[IMGSIZE-1:0];
          REG_NET_OFFSET: cfg.net_offset <= reg_wdata[NETSIZE-1:0];
          REG_TOTAL_OUT:  cfg.total_out  <= reg_wdata[LWIDTH-1:0];
          REG_TOTAL_IN:   cfg.total_in   <= reg_wdata[LWIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  assign host_sel = (owner == OWNER_HOST);
  assign fc_req   = (owner == OWNER_FC) && req;

  // Registered readback
  always_ff @(posedge clk) begin
    if (!xrst) begin
      reg_rdata <= '0;
    end else begin
      case (reg_addr)
        REG_OWNER:        reg_rdata <= reg_data_t'(owner);
        REG_REQ:          reg_rdata <= reg_data_t'(req);
        REG_IN_OFFSET:    reg_rdata <= reg_data_t'(cfg.in_offset);
        REG_OUT_OFFSET:   reg_rdata <= reg_data_t'(cfg.out_offset);
        REG_NET_OFFSET:   reg_rdata <= reg_data_t'(cfg.net_offset);
        REG_TOTAL_OUT:    reg_rdata <= reg_data_t'(cfg.total_out);
        REG_TOTAL_IN:     reg_rdata <= reg_data_t'(cfg.total_in);
        REG_ACK:          reg_rdata <= host_sel ? reg_data_t'(1) : reg_data_t'(ack);
        REG_OWNER_STATUS: reg_rdata <= reg_data_t'(owner_d);
        default:          reg_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/regmap_pkg.sv
`default_nettype none

package regmap_pkg;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  localparam reg_addr_t REG_OWNER        = 5'd0;
  localparam reg_addr_t REG_REQ          = 5'd1;
  localparam reg_addr_t REG_IN_OFFSET    = 5'd2;
  localparam reg_addr_t REG_OUT_OFFSET   = 5'd3;
  localparam reg_addr_t REG_NET_OFFSET   = 5'd4;
  localparam reg_addr_t REG_TOTAL_OUT    = 5'd5;
  localparam reg_addr_t REG_TOTAL_IN     = 5'd6;
  // Read only
  localparam reg_addr_t REG_ACK          = 5'd30;
  localparam reg_addr_t REG_OWNER_STATUS = 5'd31;

endpackage

`default_nettype wire

// File: design/weight_mem.sv
`default_nettype none

module weight_mem #(
  parameter int DATA_BITS = 16,
  parameter int ADDR_BITS = 10
) (
  input  wire logic                 clk,
  input  wire logic                 we,
  input  wire logic [ADDR_BITS-1:0] waddr,
  input  wire logic [DATA_BITS-1:0] wdata,
  input  wire logic [ADDR_BITS-1:0] raddr,
  output logic      [DATA_BITS-1:0] rdata
);

  logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: src.f
design/kinpira_pkg.sv
design/regmap_pkg.sv
design/kinpira_ifs.sv
design/weight_mem.sv
design/image_buffer.sv
design/param_regs.sv
design/fc_ctrl.sv
design/fc_counter.sv
design/fc_mac.sv
design/kinpira_top.sv
testbench/tb_kinpira.sv

// File: testbench/kinpira_patterns.txt
// First word is the number of cases
// Each case holds in_offset out_offset net_offset total_in total_out then inputs weights outputs
0002
// Case A with a saturated third output
0010 0020 0000 0004 0003
0100 0200 ff00 0080
0100 0100 0100 0100
0080 ff00 0200 0000
7f00 7f00 0000 7f00
0280 fc80 7fff
// Case B
0040 0050 0020 0003 0002
0300 fe00 0040
0100 0100 0400
ff80 0180 0000
0200 fb80

// File: testbench/tb_kinpira.sv
`default_nettype none

module tb_kinpira
  import kinpira_pkg::*;
  import regmap_pkg::*;
();

  localparam int TIMEOUT = 500;

  logic      clk;
  logic      xrst;
  logic      reg_we;
  reg_addr_t reg_addr;
  reg_data_t reg_wdata;
  reg_data_t reg_rdata;
  logic      img_we;
  img_addr_t img_addr;
  data_t     img_wdata;
  data_t     img_rdata;
  logic      net_we;
  net_addr_t net_addr;
  data_t     net_wdata;

  logic [15:0] pat [0:127];
  int          case_base [0:3];
  int          checks;
  int          errors;
  int          seed;

  kinpira_top i_dut (
    .clk       (clk),
    .xrst      (xrst),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .img_we    (img_we),
    .img_addr  (img_addr),
    .img_wdata (img_wdata),
    .img_rdata (img_rdata),
    .net_we    (net_we),
    .net_addr  (net_addr),
    .net_wdata (net_wdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  function automatic reg_data_t pat_word(input int idx);
    return {16'h0, pat[idx]};
  endfunction

  // Record layout is header, inputs, weights, expected outputs
  function automatic int next_case(input int base);
    int n_in;
    int n_out;
    n_in  = int'(pat_word(base + 3));
    n_out = int'(pat_word(base + 4));
    return base + 5 + n_in + n_in * n_out + n_out;
  endfunction

  task automatic check_value(input string name, input reg_data_t got, input reg_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    reg_addr = addr;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic write_img(input img_addr_t addr, input reg_data_t data);
    img_we    = 1'b1;
    img_addr  = addr;
    img_wdata = data_t'(data[15:0]);
    @(negedge clk);
    img_we = 1'b0;
  endtask

  task automatic read_img(input img_addr_t addr, output reg_data_t data);
    img_addr = addr;
    @(negedge clk);
    data = {16'h0, img_rdata};
  endtask

  task automatic write_net(input net_addr_t addr, input reg_data_t data);
    net_we    = 1'b1;
    net_addr  = addr;
    net_wdata = data_t'(data[15:0]);
    @(negedge clk);
    net_we = 1'b0;
  endtask

  // Poll REG_ACK until it shows the wanted level
  task automatic wait_ack(input logic level);
    reg_data_t value;
    int        n;
    n = 0;
    read_reg(REG_ACK, value);
    while (value[0] !== level && n < TIMEOUT) begin
      read_reg(REG_ACK, value);
      n++;
    end
    if (value[0] !== level) begin
      errors++;
      $display("ack did not go to %0d within %0d register reads", level, TIMEOUT);
    end
  endtask

  task automatic run_case(input int base);
    img_addr_t in_off;
    net_addr_t net_off;
    int        n_in;
    int        n_out;
    reg_data_t value;
    in_off  = img_addr_t'(pat_word(base));
    net_off = net_addr_t'(pat_word(base + 2));
    n_in    = int'(pat_word(base + 3));
    n_out   = int'(pat_word(base + 4));
    for (int i = 0; i < n_in; i++) begin
      write_img(img_addr_t'(in_off + i), pat_word(base + 5 + i));
    end
    for (int k = 0; k < n_in * n_out; k++) begin
      write_net(net_addr_t'(net_off + k), pat_word(base + 5 + n_in + k));
    end
    write_reg(REG_IN_OFFSET, pat_word(base));
    write_reg(REG_OUT_OFFSET, pat_word(base + 1));
    write_reg(REG_NET_OFFSET, pat_word(base + 2));
    write_reg(REG_TOTAL_IN, pat_word(base + 3));
    write_reg(REG_TOTAL_OUT, pat_word(base + 4));
    write_reg(REG_OWNER, reg_data_t'(OWNER_FC));
    write_reg(REG_REQ, 32'd1);
    wait_ack(1'b1);
    // Engine ownership shows up in the status register
    read_reg(REG_OWNER_STATUS, value);
    check_value("reg_rdata", value, reg_data_t'(OWNER_FC));
    write_reg(REG_REQ, 32'd0);
    wait_ack(1'b0);
    write_reg(REG_OWNER, reg_data_t'(OWNER_HOST));
  endtask

  // Inputs must be untouched and outputs must match the file
  task automatic check_case(input int base);
    img_addr_t in_off;
    img_addr_t out_off;
    int        n_in;
    int        n_out;
    reg_data_t word;
    in_off  = img_addr_t'(pat_word(base));
    out_off = img_addr_t'(pat_word(base + 1));
    n_in    = int'(pat_word(base + 3));
    n_out   = int'(pat_word(base + 4));
    for (int i = 0; i < n_in; i++) begin
      read_img(img_addr_t'(in_off + i), word);
      check_value("img_rdata", word, pat_word(base + 5 + i));
    end
    for (int o = 0; o < n_out; o++) begin
      read_img(img_addr_t'(out_off + o), word);
      check_value("img_rdata", word, pat_word(base + 5 + n_in + n_in * n_out + o));
    end
  endtask

  initial begin
    reg_data_t value;
    reg_data_t rnd;
    reg_data_t host_data [0:7];
    int        num_cases;
    int        p;
    seed      = 53986;
    checks    = 0;
    errors    = 0;
    xrst      = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    img_we    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    net_we    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;
    $readmemh("testbench/kinpira_patterns.txt", pat);
    repeat (5) @(negedge clk);
    xrst = 1'b1;

    read_reg(REG_ACK, value);
    check_value("reg_rdata", value, 32'd1);
    read_reg(REG_OWNER_STATUS, value);
    check_value("reg_rdata", value, 32'd0);
    read_reg(REG_OWNER, value);
    check_value("reg_rdata", value, 32'd0);

    // All config fields are 10 bits wide
    for (int a = REG_IN_OFFSET; a <= REG_TOTAL_IN; a++) begin
      rnd = $random(seed);
      write_reg(reg_addr_t'(a), rnd);
      read_reg(reg_addr_t'(a), value);
      check_value("reg_rdata", value, rnd & 32'h3ff);
    end
    read_reg(5'd7, value);
    check_value("reg_rdata", value, 32'd0);
    read_reg(5'd29, value);
    check_value("reg_rdata", value, 32'd0);

    for (int k = 0; k < 8; k++) begin
      host_data[k] = {16'h0, 16'($random(seed))};
      write_img(img_addr_t'(10'h200 + k), host_data[k]);
    end
    for (int k = 0; k < 8; k++) begin
      read_img(img_addr_t'(10'h200 + k), value);
      check_value("img_rdata", value, host_data[k]);
    end

    num_cases = int'(pat_word(0));
    p = 1;
    for (int c = 0; c < num_cases && c < 4; c++) begin
      case_base[c] = p;
      run_case(p);
      check_case(p);
      p = next_case(p);
    end
    // Later layers leave earlier results alone
    for (int c = 0; c < num_cases && c < 4; c++) begin
      check_case(case_base[c]);
    end

    // Host write while the engine owns the buffer
    write_reg(REG_OWNER, reg_data_t'(OWNER_FC));
    write_img(img_addr_t'(pat_word(case_base[0] + 1)), 32'h1234);
    write_reg(REG_OWNER, reg_data_t'(OWNER_HOST));
    check_case(case_base[0]);

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
